/* verilog/cordic_pkg.sv */
`default_nettype none

package cordic_pkg;

	////////////////////
	// Sizing.
	////////////////////

	// Word width for X, Y, Z and the result. Any width from 12 to 32 bits works.
	localparam int DEFAULT_DATA_W = 24;
	localparam int DEFAULT_ITERATIONS = 20;	// One pipeline stage per iteration.
	localparam int TABLE_LEN = 24;	// Upper bound on the iteration count.

	////////////////////
	// Constants in Q2.30.
	////////////////////

	// Gain compensation 0.607252935, so the rotated vector comes out at unit length.
	localparam logic signed [31:0] GAIN_Q30 = 32'sh26DD3B6A;

	// Entry i holds atan(2^-i). Past about i = 10 the value is simply 2^-i minus a hair.
	localparam logic signed [31:0] ATAN_TABLE [0:TABLE_LEN-1] = '{
		32'sh3243F6A8,	// atan(1) = pi/4.
		32'sh1DAC6705,
		32'sh0FADBAFC,
		32'sh07F56EA6,
		32'sh03FEAB76,
		32'sh01FFD55B,
		32'sh00FFFAAA,
		32'sh007FFF55,
		32'sh003FFFEA,
		32'sh001FFFFD,
		32'sh000FFFFF,
		32'sh0007FFFF,
		32'sh0003FFFF,
		32'sh0001FFFF,
		32'sh0000FFFF,
		32'sh00007FFF,
		32'sh00003FFF,
		32'sh00001FFF,
		32'sh00000FFF,
		32'sh000007FF,
		32'sh000003FF,
		32'sh000001FF,
		32'sh000000FF,
		32'sh0000007F
	};

	////////////////////
	// Codes.
	////////////////////

	localparam logic OP_COS = 1'b0;	// Result is taken from X.
	localparam logic OP_SIN = 1'b1;	// Result is taken from Y.

	// Region code from the angle folding logic. Differing bits mean the result is negated.
	typedef logic [1:0] region_t;

endpackage

`default_nettype wire

/* verilog/cordic_vec_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One CORDIC item as it moves from one pipeline register to the next.
interface cordic_vec_if #(
	parameter int DATA_W = cordic_pkg::DEFAULT_DATA_W
);
	logic                     valid;	// The register holds a live item.
	logic signed [DATA_W-1:0] x;	// Cosine side of the vector, Q2.
	logic signed [DATA_W-1:0] y;	// Sine side of the vector, Q2.
	logic signed [DATA_W-1:0] z;	// Residual angle in radians, Q2.
	logic                     op;	// Sine or cosine select, travels with the item.
	cordic_pkg::region_t      region;	// Folding code, used only at the drain.

	// The stage that owns the register.
	modport src (
		output valid,
		output x,
		output y,
		output z,
		output op,
		output region
	);

	// The stage that reads the register.
	modport dst (
		input valid,
		input x,
		input y,
		input z,
		input op,
		input region
	);
endinterface

`default_nettype wire

/* verilog/angle_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module angle_loader #(
	parameter int DATA_W = cordic_pkg::DEFAULT_DATA_W
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     advance,	// Whole pipeline steps on this edge.
	input  logic                     in_valid,
	input  logic signed [DATA_W-1:0] angle,	// Radians in Q2, already inside the CORDIC range.
	input  logic                     operation,
	input  cordic_pkg::region_t      region,
	cordic_vec_if.src                vec_out	// Link 0 of the pipeline.
);

	// The Q2.30 gain shifted down to DATA_W bits. The low fraction bits are dropped.
	localparam logic signed [31:0] GAIN_SHIFTED = cordic_pkg::GAIN_Q30 >>> (32 - DATA_W);
	localparam logic signed [DATA_W-1:0] GAIN = GAIN_SHIFTED[DATA_W-1:0];

	////////////////////
	// Valid bit.
	////////////////////

	// An input counts as accepted on any edge with advance high, since in_ready is advance.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			vec_out.valid <= 1'b0;	// Empty pipeline out of reset.
		else if (advance)
			vec_out.valid <= in_valid;
	end

	////////////////////
	// Start vector.
	////////////////////

	// Starting at (1/K, 0) means the stages leave a unit-length vector, so no final multiply.
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			vec_out.x      <= GAIN;
			vec_out.y      <= '0;
			vec_out.z      <= angle;	// Rotation mode drives Z to zero.
			vec_out.op     <= operation;
			vec_out.region <= region;
		end
	end

	// A floating in_valid would let junk into the pipeline or drop a real item.
	a_in_valid_known : assert property (
		@(posedge clk) disable iff (!rst_n) !$isunknown(in_valid)
	) else $error("angle_loader: in_valid is unknown after reset");

endmodule

`default_nettype wire

/* verilog/cordic_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_stage #(
	parameter int DATA_W = cordic_pkg::DEFAULT_DATA_W,
	parameter int STAGE  = 0	// Iteration index. Sets the shift and the table entry.
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      advance,	// Common step enable from the drain.
	cordic_vec_if.dst vec_in,
	cordic_vec_if.src vec_out
);

	// This stage's arctangent, cut from Q2.30 down to DATA_W bits the same way as the gain.
	localparam logic signed [31:0] ATAN_SHIFTED =
		cordic_pkg::ATAN_TABLE[STAGE] >>> (32 - DATA_W);
	localparam logic signed [DATA_W-1:0] ATAN = ATAN_SHIFTED[DATA_W-1:0];

	logic                     z_neg;	// Direction of this micro-rotation.
	logic signed [DATA_W-1:0] x_shift;
	logic signed [DATA_W-1:0] y_shift;
	logic signed [DATA_W-1:0] x_next;
	logic signed [DATA_W-1:0] y_next;
	logic signed [DATA_W-1:0] z_next;

	////////////////////
	// Rotation.
	////////////////////

	// Only rotation mode exists here, so the direction always comes from the sign of Z.
	assign z_neg = vec_in.z[DATA_W-1];

	// The shift replaces the multiply by 2^-STAGE. It keeps the sign and truncates.
	assign x_shift = vec_in.x >>> STAGE;
	assign y_shift = vec_in.y >>> STAGE;

	always_comb
	begin
		if (z_neg)
		begin
			// Angle left over is negative, so rotate clockwise.
			x_next = vec_in.x + y_shift;
			y_next = vec_in.y - x_shift;
			z_next = vec_in.z + ATAN;
		end
		else
		begin
			x_next = vec_in.x - y_shift;	// Counter-clockwise toward the target angle.
			y_next = vec_in.y + x_shift;
			z_next = vec_in.z - ATAN;
		end
	end

	////////////////////
	// Stage register.
	////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			vec_out.valid <= 1'b0;
		else if (advance)
			vec_out.valid <= vec_in.valid;
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			vec_out.x      <= x_next;
			vec_out.y      <= y_next;
			vec_out.z      <= z_next;
			vec_out.op     <= vec_in.op;	// Side information rides along untouched.
			vec_out.region <= vec_in.region;
		end
	end

	// When the drain stalls, the register feeding this stage has to freeze as well,
	// or an item slips past this stage and is lost.
	a_hold_on_stall : assert property (
		@(posedge clk) disable iff (!rst_n)
		!advance |=> $stable(vec_in.valid) &&
			(!vec_in.valid || $stable({vec_in.x, vec_in.y, vec_in.z, vec_in.op,
				vec_in.region}))
	) else $error("cordic_stage %0d: input register changed while stalled", STAGE);

endmodule

`default_nettype wire

/* verilog/result_select.sv */
`timescale 1ns/1ps
`default_nettype none

module result_select #(
	parameter int DATA_W = cordic_pkg::DEFAULT_DATA_W
) (
	input  logic                     clk,
	input  logic                     rst_n,
	cordic_vec_if.dst                vec_in,	// Output of the last rotation stage.
	input  logic                     out_ready,
	output logic                     advance,	// Step enable for the loader and all stages.
	output logic                     out_valid,
	output logic signed [DATA_W-1:0] result
);

	logic signed [DATA_W-1:0] picked;	// X or Y, before the region sign.
	logic                     flip;
	logic signed [DATA_W-1:0] final_val;

	////////////////////
	// Pipeline advance.
	////////////////////

	// The output register is the only place that can block. If it is empty or being read
	// this cycle, everything behind it may move one step.
	assign advance = !out_valid || out_ready;

	////////////////////
	// Result pick.
	////////////////////

	always_comb
	begin
		unique case (vec_in.op)
			cordic_pkg::OP_SIN: picked = vec_in.y;
			cordic_pkg::OP_COS: picked = vec_in.x;
		endcase
	end

	// Codes 01 and 10 mean the angle was folded across an axis and the sign must come back.
	assign flip      = vec_in.region[1] ^ vec_in.region[0];
	assign final_val = flip ? -picked : picked;	// Two's complement negate.

	////////////////////
	// Output register.
	////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (advance)
			out_valid <= vec_in.valid;	// Drops low once the consumer takes the last item.
	end

	always_ff @(posedge clk)
	begin
		if (advance)
			result <= final_val;
	end

	// A waiting result stays put until the consumer takes it.
	a_out_stable : assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> $stable(out_valid) && $stable(result)
	) else $error("result_select: output changed while waiting for out_ready");

endmodule

`default_nettype wire

/* verilog/cordic_sincos.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_sincos #(
	parameter int DATA_W     = cordic_pkg::DEFAULT_DATA_W,
	parameter int ITERATIONS = cordic_pkg::DEFAULT_ITERATIONS
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic signed [DATA_W-1:0] angle,	// Radians, Q2.
	input  logic                     operation,	// 1 for sine, 0 for cosine.
	input  logic [1:0]               region,
	output logic                     out_valid,
	input  logic                     out_ready,
	output logic signed [DATA_W-1:0] result
);

	logic advance;	// One enable for every register in the pipeline.

	// Link k feeds stage k. The last link feeds the drain.
	cordic_vec_if #(.DATA_W(DATA_W)) link [0:ITERATIONS] ();

	// Catch sizes the table or the Q2 format cannot cover.
	if (ITERATIONS < 1 || ITERATIONS > cordic_pkg::TABLE_LEN)
	begin : g_bad_iterations
		$error("cordic_sincos: ITERATIONS must be from 1 to %0d", cordic_pkg::TABLE_LEN);
	end
	if (DATA_W < 12 || DATA_W > 32)
	begin : g_bad_width
		$error("cordic_sincos: DATA_W must be from 12 to 32");
	end

	assign in_ready = advance;	// An input is taken whenever the pipeline steps.

	////////////////////
	// Pipeline.
	////////////////////

	angle_loader #(.DATA_W(DATA_W)) loader_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.advance   (advance),
		.in_valid  (in_valid),
		.angle     (angle),
		.operation (operation),
		.region    (region),
		.vec_out   (link[0])
	);

	for (genvar k = 0; k < ITERATIONS; k++)
	begin : g_stage
		cordic_stage #(.DATA_W(DATA_W), .STAGE(k)) stage_inst (
			.clk     (clk),
			.rst_n   (rst_n),
			.advance (advance),
			.vec_in  (link[k]),
			.vec_out (link[k+1])
		);
	end

	result_select #(.DATA_W(DATA_W)) drain_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.vec_in    (link[ITERATIONS]),
		.out_ready (out_ready),
		.advance   (advance),
		.out_valid (out_valid),
		.result    (result)
	);

endmodule

`default_nettype wire

/* dv/cordic_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// Scoreboard for cordic_sincos. It predicts every accepted angle and checks results in order.
module cordic_checker #(
	parameter int DATA_W     = cordic_pkg::DEFAULT_DATA_W,
	parameter int ITERATIONS = cordic_pkg::DEFAULT_ITERATIONS
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  logic                     in_ready,
	input  logic signed [DATA_W-1:0] angle,
	input  logic                     operation,
	input  logic [1:0]               region,
	input  logic                     out_valid,
	input  logic                     out_ready,
	input  logic signed [DATA_W-1:0] result,
	input  logic [127:0]             test_name,	// Label of the item now on the input.
	input  logic signed [DATA_W-1:0] approx,	// Rough value from the stimulus table.
	output int                       pass_count,
	output int                       fail_count,
	output int                       pending
);

	localparam int LATENCY    = ITERATIONS + 2;	// Accepting edge to delivering edge.
	localparam int APPROX_TOL = 2 ** (DATA_W - 12);	// Roughly 0.001 in Q2.

	// One entry per accepted input, oldest first.
	logic signed [DATA_W-1:0] exp_q [$];
	logic signed [DATA_W-1:0] approx_q [$];
	logic [127:0]             name_q [$];
	int                       cycle_q [$];
	int                       stall_q [$];

	int                       cycle = 0;
	int                       stalls = 0;	// Edges where the whole pipeline stood still.
	int                       n_pass = 0;
	int                       n_fail = 0;
	int                       n_pending = 0;
	logic                     in_reset = 1'b0;
	logic                     waiting = 1'b0;	// Last edge left a result waiting.
	logic signed [DATA_W-1:0] held;

	assign pass_count = n_pass;
	assign fail_count = n_fail;
	assign pending    = n_pending;

	////////////////////
	// Reference model.
	////////////////////

	// Start at (gain, 0), then one micro-rotation per iteration with truncating shifts.
	function automatic logic signed [DATA_W-1:0] predict(
		input logic signed [DATA_W-1:0] ang,
		input logic                     op,
		input logic [1:0]               region_code
	);
		logic signed [31:0]       wide;
		logic signed [DATA_W-1:0] x;
		logic signed [DATA_W-1:0] y;
		logic signed [DATA_W-1:0] z;
		logic signed [DATA_W-1:0] dx;
		logic signed [DATA_W-1:0] dy;
		logic signed [DATA_W-1:0] step;
		logic signed [DATA_W-1:0] v;
		int                       i;
		wide = cordic_pkg::GAIN_Q30 >>> (32 - DATA_W);
		x = wide[DATA_W-1:0];
		y = '0;
		z = ang;
		for (i = 0; i < ITERATIONS; i++)
		begin
			wide = cordic_pkg::ATAN_TABLE[i] >>> (32 - DATA_W);
			step = wide[DATA_W-1:0];
			dx = x >>> i;
			dy = y >>> i;
			if (z[DATA_W-1])
			begin
				x = x + dy;	// Negative residual, so turn clockwise.
				y = y - dx;
				z = z + step;
			end
			else
			begin
				x = x - dy;
				y = y + dx;
				z = z - step;
			end
		end
		v = op ? y : x;
		if (region_code[1] != region_code[0])
			v = -v;	// Folded angle.
		return v;
	endfunction

	////////////////////
	// Checks.
	////////////////////

	task automatic verify_reset();
		logic ok;
		ok = 1'b1;
		if (out_valid !== 1'b0)
		begin
			$display("ERROR t=%0t out_valid expected 0 got %b", $time, out_valid);
			ok = 1'b0;
		end
		if (in_ready !== 1'b1)
		begin
			$display("ERROR t=%0t in_ready expected 1 got %b", $time, in_ready);
			ok = 1'b0;
		end
		$display("test reset: %s", ok ? "ok" : "FAIL");
		if (ok)
			n_pass++;
		else
			n_fail++;
	endtask

	// A result that waits for out_ready must not move.
	task automatic watch_hold();
		if (out_valid !== 1'b1)
		begin
			$display("t=%0t: out_valid dropped before the consumer took the result", $time);
			n_fail++;
		end
		else if (result !== held)
		begin
			$display("ERROR t=%0t result expected %h got %h while waiting", $time, held, result);
			n_fail++;
		end
	endtask

	task automatic record_input();
		exp_q.push_back(predict(angle, operation, region));
		approx_q.push_back(approx);
		name_q.push_back(test_name);
		cycle_q.push_back(cycle);
		stall_q.push_back(stalls);
		n_pending++;
	endtask

	task automatic score_output();
		logic signed [DATA_W-1:0] want;
		logic signed [DATA_W-1:0] near;
		logic [127:0]             name;
		int                       took;
		int                       due;
		int                       diff;
		logic                     ok;
		if (exp_q.size() == 0)
		begin
			$display("t=%0t: a result came out with no input waiting for it", $time);
			n_fail++;
			return;
		end
		want = exp_q.pop_front();
		near = approx_q.pop_front();
		name = name_q.pop_front();
		took = cycle - cycle_q.pop_front();
		due = LATENCY + (stalls - stall_q.pop_front());	// Every stalled edge adds one.
		n_pending--;
		ok = 1'b1;
		if (result !== want)
		begin
			$display("ERROR t=%0t result expected %h got %h", $time, want, result);
			ok = 1'b0;
		end
		diff = int'(result) - int'(near);
		if (diff < 0)
			diff = -diff;
		if (diff > APPROX_TOL)
		begin
			$display("ERROR t=%0t result expected about %h got %h", $time, near, result);
			ok = 1'b0;
		end
		if (took != due)
		begin
			$display("t=%0t: result came %0d cycles after its input, not %0d", $time, took, due);
			ok = 1'b0;
		end
		$display("test %s: %s", name, ok ? "ok" : "FAIL");
		if (ok)
			n_pass++;
		else
			n_fail++;
	endtask

	// All DUT inputs change on NBAs, so values read here are the ones this edge used.
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			in_reset = 1'b1;
			waiting = 1'b0;
		end
		else
		begin
			if (in_reset)
				verify_reset();
			in_reset = 1'b0;
			cycle++;
			if (!in_ready)
				stalls++;
			if (waiting)
				watch_hold();
			if (in_valid && in_ready)
				record_input();
			if (out_valid && out_ready)
				score_output();
			waiting = out_valid && !out_ready;
			held = result;
		end
	end

endmodule

`default_nettype wire

/* dv/cordic_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_tb;

	localparam int  DATA_W          = cordic_pkg::DEFAULT_DATA_W;
	localparam int  ITERATIONS      = cordic_pkg::DEFAULT_ITERATIONS;
	localparam int  CLK_PERIOD      = 100;
	localparam int  RESET_CYCLES    = 16;
	localparam int  NUM_TESTS       = 20;
	localparam int  WATCHDOG_CYCLES = NUM_TESTS * (ITERATIONS + 2) * 4 + 100;
	localparam real PI              = 3.14159265358979;

	logic                     clk;
	logic                     rst_n;
	logic                     in_valid;
	logic                     in_ready;
	logic signed [DATA_W-1:0] angle;
	logic                     operation;
	logic [1:0]               region;
	logic                     out_valid;
	logic                     out_ready;
	logic signed [DATA_W-1:0] result;
	logic [127:0]             test_name;	// Travels with the item into the scoreboard.
	logic signed [DATA_W-1:0] approx;
	int                       pass_count;
	int                       fail_count;
	int                       pending;
	integer                   seed = 32'h68c322e1;
	int                       n_entries = 0;
	int                       idx;
	int                       delivered = 0;	// Results taken so far, which is also the
	                                        	// table index of the item at the output.
	logic                     accepted;

	// Stimulus table. The expected column is the true sine or cosine with the region sign.
	real          tab_angle [NUM_TESTS];
	logic         tab_op [NUM_TESTS];
	logic [1:0]   tab_region [NUM_TESTS];
	logic         tab_stall [NUM_TESTS];	// Random out_ready while this item waits at the output.
	real          tab_expect [NUM_TESTS];
	logic [127:0] tab_name [NUM_TESTS];

	cordic_sincos #(.DATA_W(DATA_W), .ITERATIONS(ITERATIONS)) cordic_sincos_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.angle     (angle),
		.operation (operation),
		.region    (region),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.result    (result)
	);

	cordic_checker #(.DATA_W(DATA_W), .ITERATIONS(ITERATIONS)) scoreboard_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.angle      (angle),
		.operation  (operation),
		.region     (region),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.result     (result),
		.test_name  (test_name),
		.approx     (approx),
		.pass_count (pass_count),
		.fail_count (fail_count),
		.pending    (pending)
	);

	task automatic add_entry(input real rad, input logic op, input logic [1:0] code,
		input logic stall, input real expect_val, input logic [127:0] name);
		tab_angle[n_entries] = rad;
		tab_op[n_entries] = op;
		tab_region[n_entries] = code;
		tab_stall[n_entries] = stall;
		tab_expect[n_entries] = expect_val;
		tab_name[n_entries] = name;
		n_entries++;
	endtask

	// Radians to Q2 with two integer bits. The fraction is truncated toward zero.
	function automatic logic signed [DATA_W-1:0] to_q2(input real r);
		int v;
		v = $rtoi(r * (2.0 ** (DATA_W - 2)));
		return v[DATA_W-1:0];
	endfunction

	function automatic logic random_ready();
		int rnd;
		rnd = $random(seed);
		return rnd[0];
	endfunction

	// Called right after a rising edge. Counts a result taken on that edge, then picks
	// out_ready for the next edge from the stall flag of the item now at the output.
	task automatic drive_out_ready();
		if (out_valid && out_ready)
			delivered++;
		if (delivered < n_entries && tab_stall[delivered])
			out_ready <= random_ready();
		else
			out_ready <= 1'b1;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////
	// Stimulus.
	////////////////////

	initial
	begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		angle = '0;
		operation = 1'b0;
		region = 2'b00;
		out_ready = 1'b1;
		test_name = '0;
		approx = '0;

		// Back-to-back with out_ready high, so every item must keep the fixed latency.
		add_entry(0.0, cordic_pkg::OP_COS, 2'b00, 1'b0, 1.0, "cos_zero");
		add_entry(0.0, cordic_pkg::OP_SIN, 2'b00, 1'b0, 0.0, "sin_zero");
		add_entry(PI / 6.0, cordic_pkg::OP_COS, 2'b00, 1'b0, 0.8660254038, "cos_pi_6");
		add_entry(PI / 6.0, cordic_pkg::OP_SIN, 2'b00, 1'b0, 0.5, "sin_pi_6");
		add_entry(-PI / 4.0, cordic_pkg::OP_COS, 2'b00, 1'b0, 0.7071067812, "cos_m_pi_4");
		add_entry(-PI / 4.0, cordic_pkg::OP_SIN, 2'b00, 1'b0, -0.7071067812, "sin_m_pi_4");
		add_entry(1.57079, cordic_pkg::OP_COS, 2'b00, 1'b0, 0.0, "cos_near_pi_2");
		add_entry(1.57079, cordic_pkg::OP_SIN, 2'b00, 1'b0, 1.0, "sin_near_pi_2");
		add_entry(-1.57079, cordic_pkg::OP_SIN, 2'b00, 1'b0, -1.0, "sin_near_m_pi_2");
		// Region codes. 01 and 10 negate, 11 leaves the value alone.
		add_entry(-1.57079, cordic_pkg::OP_COS, 2'b11, 1'b0, 0.0, "cos_m_pi_2_r11");
		add_entry(PI / 6.0, cordic_pkg::OP_SIN, 2'b01, 1'b0, -0.5, "sin_pi_6_r01");
		add_entry(PI / 6.0, cordic_pkg::OP_COS, 2'b10, 1'b0, -0.8660254038, "cos_pi_6_r10");
		add_entry(-PI / 4.0, cordic_pkg::OP_SIN, 2'b11, 1'b0, -0.7071067812, "sin_m_pi_4_r11");
		// Random back-pressure from here on.
		add_entry(1.0, cordic_pkg::OP_SIN, 2'b00, 1'b1, 0.8414709848, "stall_sin_1");
		add_entry(1.0, cordic_pkg::OP_COS, 2'b00, 1'b1, 0.5403023059, "stall_cos_1");
		add_entry(-0.5, cordic_pkg::OP_SIN, 2'b00, 1'b1, -0.4794255386, "stall_sin_m0p5");
		add_entry(-0.5, cordic_pkg::OP_COS, 2'b01, 1'b1, -0.8775825619, "stall_cos_m0p5");
		add_entry(1.2, cordic_pkg::OP_SIN, 2'b10, 1'b1, -0.9320390860, "stall_sin_1p2");
		add_entry(-1.5, cordic_pkg::OP_COS, 2'b11, 1'b1, 0.0707372017, "stall_cos_m1p5");
		add_entry(-0.1, cordic_pkg::OP_COS, 2'b00, 1'b1, 0.9950041653, "stall_cos_m0p1");

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		for (idx = 0; idx < n_entries; idx++)
		begin
			in_valid <= 1'b1;
			angle <= to_q2(tab_angle[idx]);
			operation <= tab_op[idx];
			region <= tab_region[idx];
			test_name <= tab_name[idx];
			approx <= to_q2(tab_expect[idx]);
			accepted = 1'b0;
			while (!accepted)
			begin
				@(posedge clk);
				accepted = in_ready;	// The value this edge used, since all drives are NBAs.
				drive_out_ready();
			end
		end
		in_valid <= 1'b0;

		// Keep pacing the output until every result is taken, then catch a duplicate.
		while (delivered < n_entries)
		begin
			@(posedge clk);
			drive_out_ready();
		end
		repeat (ITERATIONS + 4) @(posedge clk);

		$display("%0d tests passed, %0d failed, %0d results outstanding",
			pass_count, fail_count, pending);
		if (fail_count == 0 && pending == 0 && pass_count == n_entries + 1)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Ends a run that hangs, for example when a result is lost.
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d clock periods with %0d results never delivered",
			WATCHDOG_CYCLES, pending);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
verilog/cordic_pkg.sv
verilog/cordic_vec_if.sv
verilog/angle_loader.sv
verilog/cordic_stage.sv
verilog/result_select.sv
verilog/cordic_sincos.sv
dv/cordic_checker.sv
dv/cordic_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the CORDIC testbench with Verilator, runs it and scans the log for the verdict.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module cordic_tb -f build.f -o cordic_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/cordic_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi
